//--- files.f
design/load_pkg.sv
design/load_decode.sv
design/load_mem_access.sv
design/load_result.sv
design/load_fu.sv
testbench/axi_lite_read_memory.sv
testbench/load_fu_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := load_fu_tb
FILE_LIST  := files.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_TEXT  := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

# the run fails unless the pass message shows up in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

//--- testbench/load_fu_tb.sv
`timescale 1ns/1ps

module load_fu_tb;

    import load_pkg::*;

    localparam int          num_tests    = 300;
    localparam int          mem_words    = 256;
    localparam int          error_window = 192; // first word index that answers SLVERR
    localparam logic [31:0] seed_value   = 32'h30f7_9a8f;
    localparam logic [2:0]  legal_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

    logic                  clock;
    logic                  reset;
    logic                  issue_valid;
    logic                  issue_ready;
    logic [xlen-1:0]       inst;
    logic [xlen-1:0]       rs1_value;
    logic [tag_width-1:0]  issue_tag;
    logic                  result_done;
    logic [tag_width-1:0]  result_tag;
    logic [xlen-1:0]       result_value;
    fault_e                result_fault;
    logic                  result_ack;
    logic [xlen-1:0]       araddr;
    logic [2:0]            arprot;
    logic                  arvalid;
    logic                  arready;
    logic [xlen-1:0]       rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    integer           seed;
    logic [xlen-1:0]  model_mem [mem_words];
    string            test_name;
    int               test_errors;
    int               pass_count;
    int               fail_count;
    int               ar_cycles;
    int               r_handshakes;

    load_fu u_load_fu (
        .clock(clock), .reset(reset), .issue_valid(issue_valid), .issue_ready(issue_ready),
        .inst(inst), .rs1_value(rs1_value), .issue_tag(issue_tag),
        .result_done(result_done), .result_tag(result_tag), .result_value(result_value),
        .result_fault(result_fault), .result_ack(result_ack), .araddr(araddr),
        .arprot(arprot), .arvalid(arvalid), .arready(arready), .rdata(rdata),
        .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    axi_lite_read_memory #(
        .words(mem_words), .error_base(error_window), .delay_seed(seed_value)
    ) u_memory (
        .clock(clock), .reset(reset), .araddr(araddr), .arvalid(arvalid),
        .arready(arready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    function automatic logic [xlen-1:0] random_word();
        random_word = $random(seed);
    endfunction

    function automatic load_kind_e model_kind(input logic [xlen-1:0] word);
        if (word[6:0] != opcode_load) return load_illegal;
        case (word[14:12])
            3'd0: return load_byte;
            3'd1: return load_half;
            3'd2: return load_word;
            3'd4: return load_byte_unsigned;
            3'd5: return load_half_unsigned;
            default: return load_illegal;
        endcase
    endfunction

    function automatic logic [xlen-1:0] model_value(input load_kind_e kind,
                                                    input logic [xlen-1:0] addr);
        logic [xlen-1:0]  word;
        logic [7:0]       lane_b;
        logic [15:0]      lane_h;
        word   = model_mem[addr[9:2]];
        lane_b = word[{addr[1:0], 3'b000} +: 8];
        lane_h = addr[1] ? word[31:16] : word[15:0];
        case (kind)
            load_byte:          return {{24{lane_b[7]}}, lane_b};
            load_byte_unsigned: return {24'd0, lane_b};
            load_half:          return {{16{lane_h[15]}}, lane_h};
            load_half_unsigned: return {16'd0, lane_h};
            default:            return word;
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s: %s", test_name, what);
        test_errors++;
    endtask

    task automatic check_value(input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s value expected %h actual %h", test_name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_fault(input fault_e expected, input fault_e actual);
        if (expected !== actual) begin
            $display("ERROR %s fault expected %s actual %s", test_name, expected.name(),
                     actual.name());
            test_errors++;
        end
    endtask

    task automatic check_tag(input logic [tag_width-1:0] expected,
                             input logic [tag_width-1:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s tag expected %h actual %h", test_name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic close_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("PASS %s", test_name);
        end else begin
            fail_count++;
            $display("FAIL %s", test_name);
        end
    endtask

    // the bus address must stay word aligned with arprot at zero
    always @(negedge clock) begin
        if (!reset && arvalid && (araddr[1:0] != 2'b00 || arprot != 3'b000)) begin
            report_failure("AXI read address is misaligned or arprot is not zero");
        end
    end

    // bus activity counted on the edge where the DUT sees it
    always @(posedge clock) begin
        if (!reset && arvalid) begin
            ar_cycles++;
        end
        if (!reset && rvalid && rready) begin
            r_handshakes++;
        end
    end

    task automatic run_test(input int index);
        logic [xlen-1:0]       rnd;
        logic [xlen-1:0]       rnd2;
        logic [6:0]            opcode;
        logic [2:0]            funct3;
        logic [1:0]            offset;
        logic [xlen-1:0]       addr;
        load_kind_e            kind;
        fault_e                exp_fault;
        logic [xlen-1:0]       exp_value;
        logic [xlen-1:0]       held_value;
        fault_e                held_fault;
        logic [tag_width-1:0]  held_tag;
        int                    cycles;
        int                    r_cycle;
        int                    ar_start;
        int                    r_start;
        rnd    = random_word();
        rnd2   = random_word();
        opcode = opcode_load;
        offset = rnd[9:8];
        case (rnd[2:0])
            3'd5: begin // misaligned halfword or word
                funct3 = rnd[3] ? 3'd2 : (rnd[4] ? 3'd5 : 3'd1);
                if (funct3 != 3'd2) offset[0] = 1'b1;
                else if (offset == 2'd0) offset = 2'd3;
            end
            3'd6: begin // any funct3 under a major opcode that is not a load
                funct3 = rnd[5:3];
                opcode = rnd[16:10];
                if (opcode == opcode_load) opcode[2] = ~opcode[2];
            end
            3'd7: funct3 = rnd[3] ? 3'd3 : {2'b11, rnd[4]};
            default: begin
                funct3 = legal_f3[int'(rnd[12:10]) % 5];
                if (funct3[1:0] == 2'd1) offset[0] = 1'b0;
                else if (funct3[1:0] == 2'd2) offset = 2'd0;
            end
        endcase
        inst      = {rnd2[11:0], rnd2[16:12], funct3, rnd2[21:17], opcode};
        rs1_value = {22'd0, rnd[27:20], offset} - {{20{inst[31]}}, inst[31:20]};
        issue_tag = rnd2[26:22];
        addr      = rs1_value + {{20{inst[31]}}, inst[31:20]};
        kind      = model_kind(inst);
        exp_fault = fault_none;
        if (kind == load_illegal) exp_fault = fault_illegal;
        else if ((kind == load_half || kind == load_half_unsigned) && addr[0])
            exp_fault = fault_misaligned;
        else if (kind == load_word && addr[1:0] != 2'b00) exp_fault = fault_misaligned;
        else if (int'(addr[9:2]) >= error_window) exp_fault = fault_bus;
        exp_value   = (exp_fault == fault_none) ? model_value(kind, addr) : '0;
        test_name   = $sformatf("test %0d %s %s", index, kind.name(), exp_fault.name());
        test_errors = 0;
        while (!issue_ready) @(negedge clock);
        ar_start    = ar_cycles;
        r_start     = r_handshakes;
        issue_valid = 1'b1;
        @(negedge clock);
        issue_valid = 1'b0;
        cycles      = 1;
        r_cycle     = -1;
        while (!result_done) begin
            if (issue_ready) report_failure("issue_ready went high while a load was in flight");
            @(negedge clock);
            cycles++;
            if (r_cycle < 0 && r_handshakes != r_start) r_cycle = cycles - 1;
        end
        if (issue_ready) report_failure("issue_ready is high while the result is held");
        if (exp_fault == fault_illegal || exp_fault == fault_misaligned) begin
            if (cycles != 2) report_failure("result_done did not rise two cycles after accept");
        end else if (r_cycle < 0 || cycles != r_cycle + 1) begin
            report_failure("result_done did not rise one cycle after the R handshake");
        end
        check_value(exp_value, result_value);
        check_fault(exp_fault, result_fault);
        check_tag(issue_tag, result_tag);
        held_value = result_value;
        held_fault = result_fault;
        held_tag   = result_tag;
        rnd        = random_word();
        repeat (rnd[1:0]) begin // random back-pressure from the reorder buffer
            @(negedge clock);
            if (!result_done || result_value !== held_value || result_fault !== held_fault ||
                result_tag !== held_tag) begin
                report_failure("the result changed before it was acknowledged");
            end
            if (issue_ready) report_failure("issue_ready went high before retire");
        end
        result_ack = 1'b1;
        @(negedge clock);
        result_ack = 1'b0;
        if (result_done) report_failure("result_done stayed high after the retire edge");
        if (!issue_ready) report_failure("issue_ready did not rise after the retire edge");
        if ((exp_fault == fault_illegal || exp_fault == fault_misaligned) &&
            ar_cycles != ar_start) begin
            report_failure("arvalid rose during a faulted load");
        end
        close_test();
    endtask

    initial begin
        repeat (16 + (num_tests + 1) * 40) @(posedge clock);
        $display("timeout, the tests did not finish within the expected number of cycles");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        seed         = seed_value;
        reset        = 1'b1;
        issue_valid  = 1'b0;
        inst         = '0;
        rs1_value    = '0;
        issue_tag    = '0;
        result_ack   = 1'b0;
        pass_count   = 0;
        fail_count   = 0;
        test_errors  = 0;
        ar_cycles    = 0;
        r_handshakes = 0;
        test_name    = "reset";
        for (int i = 0; i < mem_words; i++) begin
            model_mem[i] = random_word();
            u_memory.write_word(i, model_mem[i]);
        end
        repeat (16) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        if (!issue_ready || result_done || arvalid || rready) begin
            report_failure("the unit is not idle after reset");
        end
        close_test();
        for (int i = 1; i <= num_tests; i++) begin
            run_test(i);
        end
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/axi_lite_read_memory.sv
`timescale 1ns/1ps

module axi_lite_read_memory #(
    parameter int          words      = 256,
    parameter int          error_base = 192,
    parameter logic [31:0] delay_seed = 32'h1
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [load_pkg::xlen-1:0]  araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [load_pkg::xlen-1:0]  rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);

    import load_pkg::*;

    localparam int         index_msb   = $clog2(words) + 1;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef enum logic [1:0] {
        wait_addr,
        addr_ready,
        wait_data,
        data_valid
    } phase_e;

    logic [xlen-1:0]  mem [words];
    phase_e           phase;
    logic [1:0]       delay;
    logic [xlen-1:0]  addr_q;
    logic             ar_taken;
    logic             r_taken;
    integer           seed;

    function automatic logic [1:0] random_delay();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rnd[1:0];
    endfunction

    // backdoor load, called by the testbench before the first access
    task automatic write_word(input int index, input logic [xlen-1:0] value);
        mem[index] = value;
    endtask

    initial begin
        seed    = delay_seed;
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = axi_resp_okay;
    end

    // handshakes are seen on the rising edge and acted on at the next falling edge
    always @(posedge clock) begin
        ar_taken <= !reset && arvalid && arready;
        r_taken  <= !reset && rvalid && rready;
    end

    always @(negedge clock) begin
        if (reset) begin
            phase   <= wait_addr;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            delay   <= random_delay();
        end else begin
            case (phase)
                wait_addr: begin
                    if (arvalid && delay == 2'd0) begin
                        arready <= 1'b1;
                        addr_q  <= araddr;
                        phase   <= addr_ready;
                    end else if (arvalid) begin
                        delay <= delay - 2'd1; // random wait before arready
                    end
                end
                addr_ready: begin
                    if (ar_taken) begin
                        arready <= 1'b0;
                        delay   <= random_delay();
                        phase   <= wait_data;
                    end
                end
                wait_data: begin
                    if (delay == 2'd0) begin
                        rvalid <= 1'b1;
                        rdata  <= mem[addr_q[index_msb:2]];
                        rresp  <= (int'(addr_q[index_msb:2]) >= error_base) ? resp_slverr
                                                                            : axi_resp_okay;
                        phase  <= data_valid;
                    end else begin
                        delay <= delay - 2'd1;
                    end
                end
                default: begin
                    if (r_taken) begin
                        rvalid <= 1'b0;
                        delay  <= random_delay();
                        phase  <= wait_addr;
                    end
                end
            endcase
        end
    end

endmodule

//--- design/load_fu.sv
`timescale 1ns/1ps

module load_fu (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            issue_valid,
    output logic                            issue_ready,
    input  logic [load_pkg::xlen-1:0]       inst,
    input  logic [load_pkg::xlen-1:0]       rs1_value,
    input  logic [load_pkg::tag_width-1:0]  issue_tag,
    output logic                            result_done,
    output logic [load_pkg::tag_width-1:0]  result_tag,
    output logic [load_pkg::xlen-1:0]       result_value,
    output load_pkg::fault_e                result_fault,
    input  logic                            result_ack,
    output logic [load_pkg::xlen-1:0]       araddr,
    output logic [2:0]                      arprot,
    output logic                            arvalid,
    input  logic                            arready,
    input  logic [load_pkg::xlen-1:0]       rdata,
    input  logic [1:0]                      rresp,
    input  logic                            rvalid,
    output logic                            rready
);

    import load_pkg::*;

    logic                  dec_valid;
    load_kind_e            dec_kind;
    logic [xlen-1:0]       dec_addr;
    fault_e                dec_fault;
    logic [tag_width-1:0]  dec_tag;
    logic                  exe_complete;
    logic [xlen-1:0]       exe_word;
    logic [1:0]            exe_byte_offset;
    load_kind_e            exe_kind;
    fault_e                exe_fault;
    logic                  ret_ack;

    load_decode u_decode (
        .clock(clock), .reset(reset), .issue_valid(issue_valid), .inst(inst),
        .rs1_value(rs1_value), .issue_tag(issue_tag), .ret_ack(ret_ack),
        .issue_ready(issue_ready), .dec_valid(dec_valid), .dec_kind(dec_kind),
        .dec_addr(dec_addr), .dec_fault(dec_fault), .dec_tag(dec_tag)
    );

    // AXI4-Lite read manager, bypassed for faulted loads
    load_mem_access u_mem_access (
        .clock(clock), .reset(reset), .dec_valid(dec_valid), .dec_kind(dec_kind),
        .dec_addr(dec_addr), .dec_fault(dec_fault), .arready(arready), .rdata(rdata),
        .rresp(rresp), .rvalid(rvalid), .araddr(araddr), .arprot(arprot),
        .arvalid(arvalid), .rready(rready), .exe_complete(exe_complete),
        .exe_word(exe_word), .exe_byte_offset(exe_byte_offset), .exe_kind(exe_kind),
        .exe_fault(exe_fault)
    );

    load_result u_result (
        .clock(clock), .reset(reset), .exe_complete(exe_complete), .exe_word(exe_word),
        .exe_byte_offset(exe_byte_offset), .exe_kind(exe_kind), .exe_fault(exe_fault),
        .dec_tag(dec_tag), .result_ack(result_ack), .result_done(result_done),
        .result_tag(result_tag), .result_value(result_value),
        .result_fault(result_fault), .ret_ack(ret_ack)
    );

endmodule

//--- design/load_result.sv
`timescale 1ns/1ps

module load_result (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            exe_complete,
    input  logic [load_pkg::xlen-1:0]       exe_word,
    input  logic [1:0]                      exe_byte_offset,
    input  load_pkg::load_kind_e            exe_kind,
    input  load_pkg::fault_e                exe_fault,
    input  logic [load_pkg::tag_width-1:0]  dec_tag,
    input  logic                            result_ack,
    output logic                            result_done,
    output logic [load_pkg::tag_width-1:0]  result_tag,
    output logic [load_pkg::xlen-1:0]       result_value,
    output load_pkg::fault_e                result_fault,
    output logic                            ret_ack
);

    import load_pkg::*;

    logic [xlen-1:0]  shifted;
    logic [xlen-1:0]  extended;

    // move the addressed lanes down to bit 0
    assign shifted = exe_word >> {exe_byte_offset, 3'b000};

    always_comb begin
        case (exe_kind)
            load_byte:          extended = {{(xlen-8){shifted[7]}}, shifted[7:0]};
            load_half:          extended = {{(xlen-16){shifted[15]}}, shifted[15:0]};
            load_word:          extended = exe_word; // always aligned, no shift
            load_byte_unsigned: extended = {{(xlen-8){1'b0}}, shifted[7:0]};
            load_half_unsigned: extended = {{(xlen-16){1'b0}}, shifted[15:0]};
            default:            extended = '0;
        endcase
        if (exe_fault != fault_none) begin
            extended = '0; // a faulted load returns zero
        end
    end

    assign ret_ack = result_done && result_ack; // retire edge frees the unit

    always_ff @(posedge clock) begin
        if (reset) begin
            result_done <= 1'b0;
        end else if (exe_complete) begin
            result_done <= 1'b1;
        end else if (ret_ack) begin
            result_done <= 1'b0;
        end
    end

    // payload only loads on completion, so it stays stable until retire
    always_ff @(posedge clock) begin
        if (exe_complete) begin
            result_value <= extended;
            result_tag   <= dec_tag;
            result_fault <= exe_fault;
        end
    end

endmodule

//--- design/load_mem_access.sv
`timescale 1ns/1ps

module load_mem_access (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       dec_valid,
    input  load_pkg::load_kind_e       dec_kind,
    input  logic [load_pkg::xlen-1:0]  dec_addr,
    input  load_pkg::fault_e           dec_fault,
    input  logic                       arready,
    input  logic [load_pkg::xlen-1:0]  rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rvalid,
    output logic [load_pkg::xlen-1:0]  araddr,
    output logic [2:0]                 arprot,
    output logic                       arvalid,
    output logic                       rready,
    output logic                       exe_complete,
    output logic [load_pkg::xlen-1:0]  exe_word,
    output logic [1:0]                 exe_byte_offset,
    output load_pkg::load_kind_e       exe_kind,
    output load_pkg::fault_e           exe_fault
);

    import load_pkg::*;

    mem_state_e  state;
    load_kind_e  kind_q;
    logic [1:0]  offset_q;
    logic        fault_bypass;
    logic        r_handshake;

    // a faulted decode never reaches the bus
    assign fault_bypass = (state == mem_idle) && dec_valid && (dec_fault != fault_none);
    assign r_handshake  = (state == mem_data) && rvalid;

    assign arprot  = 3'b000; // unprivileged, secure, data access
    assign arvalid = (state == mem_addr);
    assign rready  = (state == mem_data); // only after the address handshake

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= mem_idle;
        end else begin
            case (state)
                mem_idle: begin
                    if (dec_valid && dec_fault == fault_none) begin
                        state <= mem_addr;
                    end
                end
                mem_addr: begin
                    if (arready) begin
                        state <= mem_data;
                    end
                end
                mem_data: begin
                    if (rvalid) begin
                        state <= mem_idle;
                    end
                end
                default: state <= mem_idle;
            endcase
        end
    end

    // address and lane info are captured once and held through the bus access
    always_ff @(posedge clock) begin
        if (state == mem_idle && dec_valid) begin
            araddr   <= {dec_addr[xlen-1:2], 2'b00};
            kind_q   <= dec_kind;
            offset_q <= dec_addr[1:0];
        end
    end

    assign exe_complete = fault_bypass || r_handshake;
    assign exe_word     = rdata; // read data passes straight to the result stage

    always_comb begin
        if (state == mem_idle) begin
            exe_kind        = dec_kind;
            exe_byte_offset = dec_addr[1:0];
            exe_fault       = dec_fault;
        end else begin
            exe_kind        = kind_q;
            exe_byte_offset = offset_q;
            exe_fault       = (rresp == axi_resp_okay) ? fault_none : fault_bus;
        end
    end

endmodule

//--- design/load_decode.sv
`timescale 1ns/1ps

module load_decode (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            issue_valid,
    input  logic [load_pkg::xlen-1:0]       inst,
    input  logic [load_pkg::xlen-1:0]       rs1_value,
    input  logic [load_pkg::tag_width-1:0]  issue_tag,
    input  logic                            ret_ack,
    output logic                            issue_ready,
    output logic                            dec_valid,
    output load_pkg::load_kind_e            dec_kind,
    output logic [load_pkg::xlen-1:0]       dec_addr,
    output load_pkg::fault_e                dec_fault,
    output logic [load_pkg::tag_width-1:0]  dec_tag
);

    import load_pkg::*;

    logic             busy;
    logic             accept;
    load_kind_e       kind;
    logic [xlen-1:0]  imm;
    logic [xlen-1:0]  addr;
    fault_e           fault;

    assign issue_ready = !busy; // one load at a time, from issue to retire
    assign accept      = issue_valid && issue_ready;

    always_comb begin
        kind = load_illegal;
        if (inst[6:0] == opcode_load) begin
            case (inst[14:12])
                funct3_lb:  kind = load_byte;
                funct3_lh:  kind = load_half;
                funct3_lw:  kind = load_word;
                funct3_lbu: kind = load_byte_unsigned;
                funct3_lhu: kind = load_half_unsigned;
                default:    kind = load_illegal; // funct3 of 3, 6 and 7
            endcase
        end
    end

    assign imm  = {{(xlen-12){inst[31]}}, inst[31:20]}; // I-type immediate
    assign addr = rs1_value + imm;

    always_comb begin
        fault = fault_none;
        if (kind == load_illegal) begin
            fault = fault_illegal;
        end else if ((kind == load_half || kind == load_half_unsigned) && addr[0]) begin
            fault = fault_misaligned;
        end else if (kind == load_word && addr[1:0] != 2'b00) begin
            fault = fault_misaligned;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy      <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept; // single-cycle pulse toward execute
            if (accept) begin
                busy <= 1'b1;
            end else if (ret_ack) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            dec_kind  <= kind;
            dec_addr  <= addr;
            dec_fault <= fault;
            dec_tag   <= issue_tag; // held until the result retires
        end
    end

endmodule

//--- design/load_pkg.sv
package load_pkg;

    // datapath and address width of the RV32 core
    localparam int xlen = 32;

    // reorder-buffer tag width
    localparam int tag_width = 5;

    // RV32I major opcode shared by all loads
    localparam logic [6:0] opcode_load = 7'b000_0011;

    // funct3 encodings of the legal load instructions
    localparam logic [2:0] funct3_lb  = 3'b000;
    localparam logic [2:0] funct3_lh  = 3'b001;
    localparam logic [2:0] funct3_lw  = 3'b010;
    localparam logic [2:0] funct3_lbu = 3'b100;
    localparam logic [2:0] funct3_lhu = 3'b101;

    // AXI response code for a successful transfer
    localparam logic [1:0] axi_resp_okay = 2'b00;

    // kind of load after decode
    typedef enum logic [2:0] {
        load_byte          = 3'd0,
        load_half          = 3'd1,
        load_word          = 3'd2,
        load_byte_unsigned = 3'd3,
        load_half_unsigned = 3'd4,
        load_illegal       = 3'd5
    } load_kind_e;

    // fault reported with the result, none of them stall the unit
    typedef enum logic [1:0] {
        fault_none       = 2'd0,
        fault_illegal    = 2'd1,
        fault_misaligned = 2'd2,
        fault_bus        = 2'd3
    } fault_e;

    // states of the AXI4-Lite read manager
    typedef enum logic [1:0] {
        mem_idle = 2'd0,
        mem_addr = 2'd1,
        mem_data = 2'd2
    } mem_state_e;

endpackage
